// File: filelist.f
src/spi_cmd_pkg.sv
src/bit_fifo_async.sv
src/spi_cmd_rx.sv
src/cmd_exec.sv
src/reg_bank_arbiter.sv
src/reg_bank.sv
src/spi_reg_top.sv
bench/spi_reg_chk.sv
bench/spi_reg_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module spi_reg_tb \
    -f filelist.f -o spi_reg_sim

# The simulator exits non-zero on $fatal, so the log decides the result.
./obj_dir/spi_reg_sim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
    echo "Simulation failed, see sim.log."
    exit 1
fi
echo "Simulation passed."

// File: bench/spi_reg_tb.sv
module spi_reg_tb import spi_cmd_pkg::*; ();

    localparam int FIFO_DEPTH  = 256;
    localparam int ADDR_BITS   = 4;
    localparam int ENTRIES     = 2**ADDR_BITS;
    localparam int SPI_PERIOD  = 10;
    localparam int FRAME_WAIT  = 20;   // Bound on SPI-to-bank latency in clk_sys cycles.
    localparam int READ_CYCLES = 280;  // Outlasts one frame and its latency.
    localparam int NUM_FRAMES  = 30;
    localparam int WATCHDOG    = 20 * NUM_FRAMES * (FRAME_BITS + 2) * SPI_PERIOD;

    logic       clk_sys, clk_spi, rstb;
    logic       spi_csb, spi_mosi, host_rd, host_rvalid, full;
    reg_addr_t  host_addr;
    reg_data_t  host_rdata;
    err_count_t err_count;
    reg_data_t  model [ENTRIES];  // Expected bank contents.
    err_count_t exp_err;

    spi_reg_top #(.FIFO_DEPTH(FIFO_DEPTH), .ADDR_BITS(ADDR_BITS)) dut (
        .clk_sys(clk_sys), .clk_spi(clk_spi), .rstb(rstb), .spi_csb(spi_csb),
        .spi_mosi(spi_mosi), .host_rd(host_rd), .host_addr(host_addr),
        .host_rdata(host_rdata), .host_rvalid(host_rvalid), .full(full),
        .err_count(err_count)
    );

    always #2 clk_sys = ~clk_sys;
    always #(SPI_PERIOD / 2) clk_spi = ~clk_spi;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at time %0t: %s returned %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_count(input err_count_t got, input err_count_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at time %0t: err_count is %0d, expected %0d",
                                $time, got, exp));
        end
    endtask

    task automatic host_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk_sys);
        #1;
        host_rd   = 1'b1;
        host_addr = addr;
        @(posedge clk_sys);
        #1;
        host_rd = 1'b0;
        if (host_rvalid) abort_run("host_rvalid came one cycle after the read strobe.");
        @(posedge clk_sys);
        #1;
        if (!host_rvalid) abort_run("host_rvalid did not come two cycles after the read strobe.");
        data = host_rdata;
    endtask

    // Master changes MOSI on the falling edge so the FIFO samples a settled bit.
    task automatic send_frame(input logic [FRAME_BITS-1:0] frame);
        @(negedge clk_spi);
        spi_csb = 1'b0;
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            spi_mosi = frame[i];
            @(negedge clk_spi);
        end
        spi_csb = 1'b1;
    endtask

    task automatic run_command(input opcode_t opc, input reg_addr_t addr, input reg_data_t data);
        send_frame({opc, addr, 8'h00, data});
        repeat (FRAME_WAIT) @(posedge clk_sys);
        #1;
        case (opc)
            OPC_WRITE: model[addr[ADDR_BITS-1:0]] = data;
            OPC_CLEAR: model[addr[ADDR_BITS-1:0]] = '0;
            default:   exp_err = (exp_err == '1) ? exp_err : exp_err + 8'd1;
        endcase
        check_count(err_count, exp_err);
    endtask

    // Random upper address bits must not change which entry is read.
    task automatic check_bank();
        reg_data_t got;
        reg_addr_t addr;
        for (int a = 0; a < ENTRIES; a++) begin
            addr = reg_addr_t'($urandom());
            addr[ADDR_BITS-1:0] = a[ADDR_BITS-1:0];
            host_read(addr, got);
            check_data(got, model[a], $sformatf("read of address %h", addr));
        end
    endtask

    task automatic test_reset();
        if (full) abort_run("The FIFO reports full right after reset.");
        check_count(err_count, 8'd0);
        check_bank();
    endtask

    task automatic test_write_alias();
        reg_data_t got;
        run_command(OPC_WRITE, 8'h03, 64'h0123_4567_89ab_cdef);
        host_read(8'h03, got);
        check_data(got, 64'h0123_4567_89ab_cdef, "read after WRITE");
        host_read(8'h73, got);
        check_data(got, 64'h0123_4567_89ab_cdef, "aliased read");
        run_command(OPC_WRITE, 8'hf5, 64'hfeed_face_cafe_f00d);
        host_read(8'h05, got);
        check_data(got, 64'hfeed_face_cafe_f00d, "read after aliased WRITE");
    endtask

    task automatic test_clear();
        run_command(OPC_WRITE, 8'h09, 64'h1111_2222_3333_4444);
        run_command(OPC_WRITE, 8'h0a, 64'h5555_6666_7777_8888);
        run_command(OPC_CLEAR, 8'h09, 64'hdead_beef_dead_beef);  // Data field is ignored.
        check_bank();
    endtask

    task automatic test_bad_opcode();
        run_command(8'h00, 8'h03, '1);
        run_command(8'h7f, 8'h05, '1);
        run_command(8'hff, 8'h0a, '1);
        check_bank();
    endtask

    task automatic test_read_during_write();
        reg_data_t old_val;
        reg_data_t new_val;
        reg_data_t got;
        logic      seen_new;
        run_command(OPC_WRITE, 8'h0c, 64'h0f0f_0f0f_0f0f_0f0f);
        old_val  = 64'h0f0f_0f0f_0f0f_0f0f;
        new_val  = 64'ha5a5_5a5a_c3c3_3c3c;
        seen_new = 1'b0;
        fork
            send_frame({OPC_WRITE, 8'h0c, 8'h00, new_val});
            for (int k = 0; k < READ_CYCLES + 2; k++) begin
                @(posedge clk_sys);
                #1;
                if (host_rvalid !== (k >= 2 && k % 2 == 0))
                    abort_run("host_rvalid timing broke while a WRITE frame completed.");
                if (host_rvalid && host_rdata === new_val)
                    seen_new = 1'b1;
                else if (host_rvalid)
                    check_data(host_rdata, seen_new ? new_val : old_val, "read during WRITE");
                host_rd   = (k < READ_CYCLES) && (k % 2 == 0);
                host_addr = 8'h0c;
            end
        join
        model[12] = new_val;
        if (!seen_new) abort_run("The host never saw the new value while polling.");
        host_read(8'h0c, got);
        check_data(got, new_val, "final read after WRITE");
    endtask

    task automatic test_random_writes();
        reg_addr_t addr;
        reg_data_t data;
        reg_data_t got;
        for (int n = 0; n < 20; n++) begin
            addr = reg_addr_t'($urandom());
            data = {$urandom(), $urandom()};
            run_command(OPC_WRITE, addr, data);
            host_read(addr, got);
            check_data(got, data, "random WRITE read-back");
        end
        check_bank();
    endtask

    initial begin
        #(WATCHDOG);
        abort_run("Watchdog timeout: the tests did not finish in time.");
    end

    initial begin
        void'($urandom(72652));
        clk_sys   = 1'b0;
        clk_spi   = 1'b0;
        rstb      = 1'b0;
        spi_csb   = 1'b1;
        spi_mosi  = 1'b0;
        host_rd   = 1'b0;
        host_addr = '0;
        exp_err   = '0;
        foreach (model[i]) model[i] = '0;
        repeat (4) @(posedge clk_sys);
        #1;
        rstb = 1'b1;
        test_reset();
        test_write_alias();
        test_clear();
        test_bad_opcode();
        test_read_during_write();
        test_random_writes();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: bench/spi_reg_chk.sv
module spi_reg_chk (
    input logic clk_sys,
    input logic rstb,
    input logic host_rd,
    input logic host_rvalid,
    input logic wr_req,
    input logic bank_we
);

    // Read data comes exactly two cycles after each strobe and at no other time.
    rvalid_timing: assert property (@(posedge clk_sys) disable iff (!rstb)
        host_rvalid == $past(host_rd, 2))
        else $error("host_rvalid does not follow host_rd by two cycles");

    host_gap: assert property (@(posedge clk_sys) disable iff (!rstb)
        !(host_rd && $past(host_rd)))
        else $error("host_rd asserted in two consecutive cycles");

    // A write pushed back by a host read reaches the bank in the next cycle.
    write_grant: assert property (@(posedge clk_sys) disable iff (!rstb)
        wr_req && !bank_we |=> bank_we)
        else $error("deferred write was not granted in the next cycle");

endmodule

bind reg_bank_arbiter spi_reg_chk u_chk (
    .clk_sys(clk_sys), .rstb(rstb), .host_rd(host_rd), .host_rvalid(host_rvalid),
    .wr_req(wr_req), .bank_we(bank_we)
);

// File: src/spi_reg_top.sv
module spi_reg_top import spi_cmd_pkg::*; #(
    parameter int FIFO_DEPTH = 256,
    parameter int ADDR_BITS  = 4
) (
    input  logic       clk_sys,
    input  logic       clk_spi,
    input  logic       rstb,
    input  logic       spi_csb,
    input  logic       spi_mosi,
    input  logic       host_rd,
    input  reg_addr_t  host_addr,
    output reg_data_t  host_rdata,
    output logic       host_rvalid,
    output logic       full,
    output err_count_t err_count
);

    logic                 fifo_rd;
    logic                 fifo_empty;
    logic                 fifo_bit;
    logic                 frame_valid;
    opcode_t              frame_opcode;
    payload_t             frame_payload;
    logic                 wr_req;
    reg_addr_t            wr_addr;
    reg_data_t            wr_data;
    logic                 bank_we;
    logic                 bank_re;
    logic [ADDR_BITS-1:0] bank_addr;
    reg_data_t            bank_wdata;
    reg_data_t            rd_data;

    bit_fifo_async #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .rstb(rstb), .clk_spi(clk_spi), .wr_en(!spi_csb), .din(spi_mosi),
        .clk_sys(clk_sys), .rd_en(fifo_rd), .dout(fifo_bit),
        .full(full), .empty(fifo_empty)
    );

    spi_cmd_rx u_rx (
        .clk_sys(clk_sys), .rstb(rstb), .fifo_empty(fifo_empty), .fifo_bit(fifo_bit),
        .fifo_rd(fifo_rd), .frame_valid(frame_valid),
        .frame_opcode(frame_opcode), .frame_payload(frame_payload)
    );

    cmd_exec u_exec (
        .clk_sys(clk_sys), .rstb(rstb), .frame_valid(frame_valid),
        .frame_opcode(frame_opcode), .frame_payload(frame_payload),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .err_count(err_count)
    );

    reg_bank_arbiter #(.ADDR_BITS(ADDR_BITS)) u_arb (
        .clk_sys(clk_sys), .rstb(rstb), .host_rd(host_rd), .host_addr(host_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .rd_data(rd_data),
        .host_rdata(host_rdata), .host_rvalid(host_rvalid), .bank_we(bank_we),
        .bank_re(bank_re), .bank_addr(bank_addr), .bank_wdata(bank_wdata)
    );

    reg_bank #(.ADDR_BITS(ADDR_BITS)) u_bank (
        .clk_sys(clk_sys), .rstb(rstb), .we(bank_we), .re(bank_re),
        .addr(bank_addr), .wdata(bank_wdata), .rdata(rd_data)
    );

endmodule

// File: src/reg_bank.sv
module reg_bank import spi_cmd_pkg::*; #(
    parameter int ADDR_BITS = 4
) (
    input  logic                 clk_sys,
    input  logic                 rstb,
    input  logic                 we,
    input  logic                 re,
    input  logic [ADDR_BITS-1:0] addr,
    input  reg_data_t            wdata,
    output reg_data_t            rdata
);

    reg_data_t mem [2**ADDR_BITS];

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            for (int i = 0; i < 2**ADDR_BITS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (re) begin
            rdata <= mem[addr];   // Valid the cycle after the grant.
        end
    end

endmodule

// File: src/reg_bank_arbiter.sv
module reg_bank_arbiter import spi_cmd_pkg::*; #(
    parameter int ADDR_BITS = 4
) (
    input  logic                 clk_sys,
    input  logic                 rstb,
    input  logic                 host_rd,
    input  reg_addr_t            host_addr,
    input  logic                 wr_req,
    input  reg_addr_t            wr_addr,
    input  reg_data_t            wr_data,
    input  reg_data_t            rd_data,
    output reg_data_t            host_rdata,
    output logic                 host_rvalid,
    output logic                 bank_we,
    output logic                 bank_re,
    output logic [ADDR_BITS-1:0] bank_addr,
    output reg_data_t            bank_wdata
);

    logic                 pend_valid;
    logic [ADDR_BITS-1:0] pend_addr;
    reg_data_t            pend_data;
    logic                 grant_pend;
    logic                 grant_new;
    logic                 hold_new;
    logic                 rd_granted;   // Bank is returning data this cycle.

    // Host reads always win; a colliding write waits one cycle in the slot.
    assign grant_pend = pend_valid && !host_rd;
    assign grant_new  = wr_req && !host_rd && !pend_valid;
    assign hold_new   = wr_req && !grant_new;

    assign bank_re    = host_rd;
    assign bank_we    = grant_pend || grant_new;
    assign bank_addr  = host_rd    ? host_addr[ADDR_BITS-1:0] :
                        grant_pend ? pend_addr : wr_addr[ADDR_BITS-1:0];
    assign bank_wdata = grant_pend ? pend_data : wr_data;

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            pend_valid  <= 1'b0;
            rd_granted  <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            pend_valid  <= hold_new || (pend_valid && host_rd);
            rd_granted  <= host_rd;
            host_rvalid <= rd_granted;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (hold_new) begin
            pend_addr <= wr_addr[ADDR_BITS-1:0];
            pend_data <= wr_data;
        end
        if (rd_granted) begin
            host_rdata <= rd_data;
        end
    end

endmodule

// File: src/cmd_exec.sv
module cmd_exec import spi_cmd_pkg::*; (
    input  logic       clk_sys,
    input  logic       rstb,
    input  logic       frame_valid,
    input  opcode_t    frame_opcode,
    input  payload_t   frame_payload,
    output logic       wr_req,
    output reg_addr_t  wr_addr,
    output reg_data_t  wr_data,
    output err_count_t err_count
);

    logic is_write;
    logic is_clear;
    logic known;

    assign is_write = (frame_opcode == OPC_WRITE);
    assign is_clear = (frame_opcode == OPC_CLEAR);
    assign known    = is_write || is_clear;

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            wr_req    <= 1'b0;
            err_count <= '0;
        end else begin
            wr_req <= frame_valid && known;
            if (frame_valid && !known && err_count != '1) begin
                err_count <= err_count + 1'b1;  // Holds at 255 once there.
            end
        end
    end

    // Address sits in the top payload byte, data in the low 64 bits.
    always_ff @(posedge clk_sys) begin
        if (frame_valid && known) begin
            wr_addr <= frame_payload[$bits(payload_t)-1 -: $bits(reg_addr_t)];
            wr_data <= is_write ? frame_payload[$bits(reg_data_t)-1:0] : '0;
        end
    end

endmodule

// File: src/spi_cmd_rx.sv
module spi_cmd_rx import spi_cmd_pkg::*; (
    input  logic     clk_sys,
    input  logic     rstb,
    input  logic     fifo_empty,
    input  logic     fifo_bit,
    output logic     fifo_rd,
    output logic     frame_valid,
    output opcode_t  frame_opcode,
    output payload_t frame_payload
);

    localparam int CW = $clog2(FRAME_BITS);
    localparam logic [CW-1:0] LAST_OPC_BIT = CW'($bits(opcode_t) - 1);
    localparam logic [CW-1:0] LAST_BIT     = CW'(FRAME_BITS - 1);

    rx_state_t       state;
    logic [CW-1:0]   bit_cnt;   // Bits taken so far in this frame.

    // One pop per cycle while a bit is waiting and a frame is open.
    assign fifo_rd = (state != IDLE) && !fifo_empty;

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (!fifo_empty) begin
                        state <= READ_OPCODE;
                    end
                end
                READ_OPCODE: begin
                    if (fifo_rd) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_OPC_BIT) begin
                            state <= READ_DATA;
                        end
                    end
                end
                READ_DATA: begin
                    if (fifo_rd) begin
                        if (bit_cnt == LAST_BIT) begin
                            state       <= IDLE;
                            bit_cnt     <= '0;
                            frame_valid <= 1'b1;  // Payload holds the last bit by now.
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // MSB arrives first, so each new bit enters at the bottom.
    always_ff @(posedge clk_sys) begin
        if (fifo_rd && state == READ_OPCODE) begin
            frame_opcode <= {frame_opcode[$bits(opcode_t)-2:0], fifo_bit};
        end
        if (fifo_rd && state == READ_DATA) begin
            frame_payload <= {frame_payload[$bits(payload_t)-2:0], fifo_bit};
        end
    end

endmodule

// File: src/bit_fifo_async.sv
module bit_fifo_async #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic rstb,
    input  logic clk_spi,
    input  logic wr_en,
    input  logic din,
    input  logic clk_sys,
    input  logic rd_en,
    output logic dout,
    output logic full,
    output logic empty
);

    localparam int AW = $clog2(FIFO_DEPTH);
    // Full when the two top Gray bits differ and the rest match.
    localparam logic [AW:0] FULL_MASK = (AW + 1)'(3) << (AW - 1);

    logic mem [FIFO_DEPTH];

    logic [AW:0] wr_bin;
    logic [AW:0] wr_gray;
    logic [AW:0] wr_bin_next;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_gray;
    logic [AW:0] rd_bin_next;

    logic [AW:0] rd_gray_s1;   // Read pointer seen from the SPI side.
    logic [AW:0] rd_gray_s2;
    logic [AW:0] wr_gray_s1;   // Write pointer seen from the system side.
    logic [AW:0] wr_gray_s2;

    logic push;
    logic pop;

    assign push = wr_en && !full;   // A bit offered while full is dropped.
    assign pop  = rd_en && !empty;

    assign wr_bin_next = wr_bin + {{AW{1'b0}}, push};
    assign rd_bin_next = rd_bin + {{AW{1'b0}}, pop};

    always_ff @(posedge clk_spi) begin
        if (push) begin
            mem[wr_bin[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge clk_spi or negedge rstb) begin
        if (!rstb) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    always_ff @(posedge clk_sys or negedge rstb) begin
        if (!rstb) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign full  = (wr_gray == (rd_gray_s2 ^ FULL_MASK));
    assign empty = (rd_gray == wr_gray_s2);

    // First-word fall-through, the head bit is visible before the pop.
    assign dout = mem[rd_bin[AW-1:0]];

endmodule

// File: src/spi_cmd_pkg.sv
package spi_cmd_pkg;

    typedef logic [7:0]  opcode_t;     // Command opcode.
    typedef logic [79:0] payload_t;    // Address byte, spare byte, then 64 data bits.
    typedef logic [7:0]  reg_addr_t;   // Only the low ADDR_BITS bits select an entry.
    typedef logic [63:0] reg_data_t;
    typedef logic [7:0]  err_count_t;  // Saturates at 255.

    localparam opcode_t OPC_WRITE = 8'h01;
    localparam opcode_t OPC_CLEAR = 8'h02;

    // One frame is the opcode followed by the payload.
    localparam int FRAME_BITS = 88;

    typedef enum logic [1:0] {
        IDLE,
        READ_OPCODE,
        READ_DATA
    } rx_state_t;

endpackage
